// ==== design/fpu_defines.svh ====
// FPU format constants
// Field widths and the reserved exponent codes of the custom
// sign / 7-bit exponent / 15-bit mantissa number format

`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Field widths
`define FPU_EXP_W 7
`define FPU_MANT_W 15

// Two guard bits above the mantissa for carries
`define FPU_RAW_W 17

// Reserved exponents, 63 and -64 in two's complement
`define FPU_EXP_INF 7'sh3f
`define FPU_EXP_ZERO 7'sh40

// Explicit leading one alone
`define FPU_MANT_SPECIAL 15'h4000

`endif

// ==== design/fpu_format_pkg.sv ====
// FPU number format types
// Exponent, mantissa and raw magnitude types, plus the special
// result kinds carried down the pipeline

`include "fpu_defines.svh"

package fpu_format_pkg;

    // Unbiased two's-complement exponent
    typedef logic signed [`FPU_EXP_W-1:0] fpu_exp_t;

    // Mantissa, top bit is the explicit leading one
    typedef logic [`FPU_MANT_W-1:0] fpu_mant_t;

    // Unnormalized magnitude out of the execute stage
    typedef logic [`FPU_RAW_W-1:0] fpu_raw_t;

    // Room for exponent sums and the range check
    typedef logic signed [`FPU_EXP_W+1:0] fpu_wide_exp_t;

    // Forced result kind from special operands
    typedef enum logic [1:0] {
        SPC_NONE = 2'd0,
        SPC_ZERO = 2'd1,
        SPC_INF  = 2'd2
    } fpu_special_t;

endpackage

// ==== design/fpu_ctrl_pkg.sv ====
// FPU control types
// Opcodes seen at the top level and the execute stage FSM states

package fpu_ctrl_pkg;

    // Operation select, sampled with start
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } fpu_op_t;

    // Execute FSM
    typedef enum logic [1:0] {
        EX_IDLE = 2'd0,
        EX_ADD  = 2'd1,
        EX_MUL  = 2'd2,
        EX_OUT  = 2'd3
    } exec_state_t;

endpackage

// ==== design/fpu_decode.sv ====
// FPU decode stage
// Captures the operands on an accepted start, marks special operands
// and aligns the mantissas for addition and subtraction

`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_decode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  fpu_ctrl_pkg::fpu_op_t         op,
    input  logic                          a_sign,
    input  fpu_format_pkg::fpu_exp_t      a_exp,
    input  fpu_format_pkg::fpu_mant_t     a_mant,
    input  logic                          b_sign,
    input  fpu_format_pkg::fpu_exp_t      b_exp,
    input  fpu_format_pkg::fpu_mant_t     b_mant,
    input  logic                          ready,
    output logic                          dec_valid,
    output logic                          dec_is_mul,
    output logic                          dec_subtract,
    output fpu_format_pkg::fpu_mant_t     dec_mant_big,
    output fpu_format_pkg::fpu_mant_t     dec_mant_small,
    output fpu_format_pkg::fpu_wide_exp_t dec_exp,
    output logic                          dec_sign,
    output fpu_format_pkg::fpu_special_t  dec_special
);
    import fpu_format_pkg::*;
    import fpu_ctrl_pkg::*;

    logic                   accept;
    logic                   is_mul;
    logic                   a_inf;
    logic                   b_inf;
    logic                   a_zero;
    logic                   b_zero;
    logic                   b_sign_eff;
    fpu_mant_t              a_mag;
    fpu_mant_t              b_mag;
    fpu_wide_exp_t          exp_diff;
    logic [`FPU_EXP_W+1:0]  shift_amt;
    logic                   a_first;
    fpu_mant_t              pre_small;
    fpu_mant_t              mant_big;
    fpu_mant_t              mant_small;
    fpu_wide_exp_t          base_exp;
    logic                   base_sign;
    logic                   subtract;
    fpu_special_t           special;

    assign accept = start && ready;
    assign is_mul = (op == OP_MUL);

    // Reserved exponents mark the special operands
    assign a_inf  = (a_exp == `FPU_EXP_INF);
    assign b_inf  = (b_exp == `FPU_EXP_INF);
    assign a_zero = (a_exp == `FPU_EXP_ZERO);
    assign b_zero = (b_exp == `FPU_EXP_ZERO);

    assign b_sign_eff = (op == OP_SUB) ? ~b_sign : b_sign;
    assign a_mag      = a_zero ? '0 : a_mant;
    assign b_mag      = b_zero ? '0 : b_mant;

    always_comb begin
        exp_diff  = fpu_wide_exp_t'(a_exp) - fpu_wide_exp_t'(b_exp);
        a_first   = !exp_diff[`FPU_EXP_W+1];
        shift_amt = a_first ? exp_diff : -exp_diff;
        pre_small = a_first ? b_mag : a_mag;

        if (is_mul) begin
            mant_big   = a_mant;
            mant_small = b_mant;
            base_exp   = fpu_wide_exp_t'(a_exp) + fpu_wide_exp_t'(b_exp);
            base_sign  = a_sign ^ b_sign;
            subtract   = 1'b0;
        end else begin
            // Larger exponent first, the other one shifted down
            mant_big   = a_first ? a_mag : b_mag;
            mant_small = (shift_amt >= 9'd16) ? '0 : pre_small >> shift_amt[3:0];
            base_exp   = a_first ? fpu_wide_exp_t'(a_exp) : fpu_wide_exp_t'(b_exp);
            base_sign  = a_first ? a_sign : b_sign_eff;
            subtract   = a_sign ^ b_sign_eff;
        end

        if (a_inf || b_inf) begin
            special = SPC_INF;
        end else if (is_mul && (a_zero || b_zero)) begin
            special = SPC_ZERO;
        end else begin
            special = SPC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_is_mul     <= is_mul;
            dec_subtract   <= subtract;
            dec_mant_big   <= mant_big;
            dec_mant_small <= mant_small;
            dec_exp        <= base_exp;
            dec_sign       <= base_sign;
            dec_special    <= special;
        end
    end

endmodule

// ==== design/fpu_execute.sv ====
// FPU execute stage
// One-cycle mantissa add/subtract, or a 15-step shift-add multiply
// with one multiplier bit retired per cycle

`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_execute (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          dec_valid,
    input  logic                          dec_is_mul,
    input  logic                          dec_subtract,
    input  fpu_format_pkg::fpu_mant_t     dec_mant_big,
    input  fpu_format_pkg::fpu_mant_t     dec_mant_small,
    input  fpu_format_pkg::fpu_wide_exp_t dec_exp,
    input  logic                          dec_sign,
    input  fpu_format_pkg::fpu_special_t  dec_special,
    output logic                          exe_valid,
    output fpu_format_pkg::fpu_raw_t      exe_raw,
    output fpu_format_pkg::fpu_wide_exp_t exe_exp,
    output logic                          exe_sign,
    output fpu_format_pkg::fpu_special_t  exe_special,
    output logic                          exe_is_product
);
    import fpu_format_pkg::*;
    import fpu_ctrl_pkg::*;

    exec_state_t            state;
    logic [3:0]             step;

    fpu_raw_t               add_sum;
    fpu_raw_t               add_diff;
    logic                   add_neg;
    logic [`FPU_MANT_W:0]   partial;

    fpu_raw_t               sum_q;
    fpu_mant_t              mcand;
    fpu_mant_t              prod_hi;
    fpu_mant_t              prod_lo;
    fpu_wide_exp_t          exp_q;
    logic                   sign_q;
    fpu_special_t           special_q;
    logic                   is_mul_q;

    assign add_sum  = fpu_raw_t'(dec_mant_big) + fpu_raw_t'(dec_mant_small);
    assign add_diff = fpu_raw_t'(dec_mant_big) - fpu_raw_t'(dec_mant_small);
    assign add_neg  = !dec_is_mul && dec_subtract && add_diff[`FPU_RAW_W-1];

    // Multiplier LSB picks whether the multiplicand is added this step
    assign partial = {1'b0, prod_hi} + (prod_lo[0] ? {1'b0, mcand} : '0);

    //////////////////////////////////////////////////
    // Control FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EX_IDLE;
            step  <= 4'd0;
        end else begin
            case (state)
                EX_IDLE: begin
                    step <= 4'd0;
                    if (dec_valid) begin
                        state <= dec_is_mul ? EX_MUL : EX_ADD;
                    end
                end
                EX_ADD: begin
                    state <= EX_IDLE;
                end
                EX_MUL: begin
                    step <= step + 4'd1;
                    if (step == 4'd14) begin
                        state <= EX_OUT;
                    end
                end
                default: begin
                    state <= EX_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == EX_IDLE && dec_valid) begin
            exp_q     <= dec_exp;
            special_q <= dec_special;
            is_mul_q  <= dec_is_mul;
            mcand     <= dec_mant_big;
            prod_hi   <= '0;
            prod_lo   <= dec_mant_small;
            // Negative difference comes back as a magnitude, sign flipped
            if (add_neg) begin
                sum_q  <= -add_diff;
                sign_q <= ~dec_sign;
            end else begin
                sum_q  <= dec_subtract ? add_diff : add_sum;
                sign_q <= dec_sign;
            end
        end else if (state == EX_MUL) begin
            {prod_hi, prod_lo} <= {partial, prod_lo[`FPU_MANT_W-1:1]};
        end
    end

    assign exe_valid = (state == EX_ADD) || (state == EX_OUT);

    // Product bits 29..14, i.e. the 30-bit product scaled back by 2^14
    assign exe_raw = is_mul_q ? {1'b0, prod_hi, prod_lo[`FPU_MANT_W-1]} : sum_q;

    assign exe_exp        = exp_q;
    assign exe_sign       = sign_q;
    assign exe_special    = special_q;
    assign exe_is_product = is_mul_q;

endmodule

// ==== design/fpu_result.sv ====
// FPU result stage
// Normalizes the raw magnitude, checks the exponent range, applies
// the special overrides and registers the outputs with a done pulse

`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_result (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic                          exe_valid,
    input  fpu_format_pkg::fpu_raw_t      exe_raw,
    input  fpu_format_pkg::fpu_wide_exp_t exe_exp,
    input  logic                          exe_sign,
    input  fpu_format_pkg::fpu_special_t  exe_special,
    input  logic                          exe_is_product,
    output logic                          res_sign,
    output fpu_format_pkg::fpu_exp_t      res_exp,
    output fpu_format_pkg::fpu_mant_t     res_mant,
    output logic                          zero_flag,
    output logic                          overflow_flag,
    output logic                          underflow_flag,
    output logic                          ready,
    output logic                          done
);
    import fpu_format_pkg::*;

    logic           busy;
    logic [3:0]     lz;
    fpu_raw_t       shifted;
    fpu_mant_t      norm_mant;
    fpu_wide_exp_t  norm_exp;
    logic           out_sign;
    fpu_exp_t       out_exp;
    fpu_mant_t      out_mant;
    logic           out_zero;
    logic           out_ovf;
    logic           out_unf;

    // Zeros above the leading-one position, bit 14 downwards
    function automatic logic [3:0] lead_zeros(input fpu_raw_t value);
        logic [3:0] count;
        logic       found;
        count = 4'd0;
        found = 1'b0;
        for (int i = `FPU_MANT_W - 1; i >= 0; i--) begin
            if (!found && !value[i]) begin
                count = count + 4'd1;
            end else begin
                found = 1'b1;
            end
        end
        return count;
    endfunction

    always_comb begin
        // Products of normal operands already have the leading one at bit 14 or 15
        lz      = exe_is_product ? 4'd0 : lead_zeros(exe_raw);
        shifted = exe_raw << lz;
        if (exe_raw[`FPU_MANT_W]) begin
            norm_mant = exe_raw[`FPU_MANT_W:1];
            norm_exp  = exe_exp + 9'sd1;
        end else begin
            norm_mant = shifted[`FPU_MANT_W-1:0];
            norm_exp  = exe_exp - $signed({5'b0, lz});
        end

        out_sign = exe_sign;
        out_exp  = norm_exp[`FPU_EXP_W-1:0];
        out_mant = norm_mant;
        out_zero = 1'b0;
        out_ovf  = 1'b0;
        out_unf  = 1'b0;

        // Zero results always come out positive
        if (exe_special == SPC_INF) begin
            out_exp  = `FPU_EXP_INF;
            out_mant = `FPU_MANT_SPECIAL;
        end else if (exe_special == SPC_ZERO || exe_raw == '0) begin
            out_sign = 1'b0;
            out_exp  = `FPU_EXP_ZERO;
            out_mant = `FPU_MANT_SPECIAL;
            out_zero = 1'b1;
        end else if (norm_exp > 9'sd62) begin
            out_exp  = `FPU_EXP_INF;
            out_mant = `FPU_MANT_SPECIAL;
            out_ovf  = 1'b1;
        end else if (norm_exp < -9'sd63) begin
            out_sign = 1'b0;
            out_exp  = `FPU_EXP_ZERO;
            out_mant = `FPU_MANT_SPECIAL;
            out_zero = 1'b1;
            out_unf  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy           <= 1'b0;
            done           <= 1'b0;
            res_sign       <= 1'b0;
            res_exp        <= `FPU_EXP_ZERO;
            res_mant       <= `FPU_MANT_SPECIAL;
            zero_flag      <= 1'b0;
            overflow_flag  <= 1'b0;
            underflow_flag <= 1'b0;
        end else begin
            done <= exe_valid;
            if (exe_valid) begin
                busy           <= 1'b0;
                res_sign       <= out_sign;
                res_exp        <= out_exp;
                res_mant       <= out_mant;
                zero_flag      <= out_zero;
                overflow_flag  <= out_ovf;
                underflow_flag <= out_unf;
            end else if (start && !busy) begin
                busy <= 1'b1;
            end
        end
    end

    assign ready = ~busy;

endmodule

// ==== design/fpu_top.sv ====
// FPU top level
// Decode, execute and result stages in a row, one operation in
// flight, start/idle/done handshake

`timescale 1ns/1ps

module fpu_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  fpu_ctrl_pkg::fpu_op_t     op,
    input  logic                      a_sign,
    input  fpu_format_pkg::fpu_exp_t  a_exp,
    input  fpu_format_pkg::fpu_mant_t a_mant,
    input  logic                      b_sign,
    input  fpu_format_pkg::fpu_exp_t  b_exp,
    input  fpu_format_pkg::fpu_mant_t b_mant,
    output logic                      res_sign,
    output fpu_format_pkg::fpu_exp_t  res_exp,
    output fpu_format_pkg::fpu_mant_t res_mant,
    output logic                      zero_flag,
    output logic                      overflow_flag,
    output logic                      underflow_flag,
    output logic                      idle,
    output logic                      done
);
    import fpu_format_pkg::*;

    // Decode to execute
    logic           dec_valid;
    logic           dec_is_mul;
    logic           dec_subtract;
    fpu_mant_t      dec_mant_big;
    fpu_mant_t      dec_mant_small;
    fpu_wide_exp_t  dec_exp;
    logic           dec_sign;
    fpu_special_t   dec_special;

    // Execute to result
    logic           exe_valid;
    fpu_raw_t       exe_raw;
    fpu_wide_exp_t  exe_exp;
    logic           exe_sign;
    fpu_special_t   exe_special;
    logic           exe_is_product;

    fpu_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .op             (op),
        .a_sign         (a_sign),
        .a_exp          (a_exp),
        .a_mant         (a_mant),
        .b_sign         (b_sign),
        .b_exp          (b_exp),
        .b_mant         (b_mant),
        .ready          (idle),
        .dec_valid      (dec_valid),
        .dec_is_mul     (dec_is_mul),
        .dec_subtract   (dec_subtract),
        .dec_mant_big   (dec_mant_big),
        .dec_mant_small (dec_mant_small),
        .dec_exp        (dec_exp),
        .dec_sign       (dec_sign),
        .dec_special    (dec_special)
    );

    fpu_execute u_execute (
        .clk            (clk),
        .reset          (reset),
        .dec_valid      (dec_valid),
        .dec_is_mul     (dec_is_mul),
        .dec_subtract   (dec_subtract),
        .dec_mant_big   (dec_mant_big),
        .dec_mant_small (dec_mant_small),
        .dec_exp        (dec_exp),
        .dec_sign       (dec_sign),
        .dec_special    (dec_special),
        .exe_valid      (exe_valid),
        .exe_raw        (exe_raw),
        .exe_exp        (exe_exp),
        .exe_sign       (exe_sign),
        .exe_special    (exe_special),
        .exe_is_product (exe_is_product)
    );

    // Result stage ready doubles as the idle output
    fpu_result u_result (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .exe_valid      (exe_valid),
        .exe_raw        (exe_raw),
        .exe_exp        (exe_exp),
        .exe_sign       (exe_sign),
        .exe_special    (exe_special),
        .exe_is_product (exe_is_product),
        .res_sign       (res_sign),
        .res_exp        (res_exp),
        .res_mant       (res_mant),
        .zero_flag      (zero_flag),
        .overflow_flag  (overflow_flag),
        .underflow_flag (underflow_flag),
        .ready          (idle),
        .done           (done)
    );

endmodule

// ==== tb/fpu_tb_tests.svh ====
// FPU directed tests
// One task per behavior, included into the testbench module

`ifndef FPU_TB_TESTS_SVH
`define FPU_TB_TESTS_SVH

task automatic test_reset_state();
    check_status("reset_state", 1'b1, 1'b0);
    check_flags("reset_state", 1'b0, 1'b0, 1'b0);
    check_number("reset_state", 1'b0, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL);
endtask

task automatic test_add();
    // Same exponent, carry into bit 15
    run_op("add_equal_exp", OP_ADD, 1'b0, 7'sd3, 15'h6000, 1'b0, 7'sd3, 15'h5000);
    run_op("add_diff_exp", OP_ADD, 1'b0, 7'sd5, 15'h4000, 1'b0, 7'sd2, 15'h6000);
    run_op("add_mixed_sign", OP_ADD, 1'b1, 7'sd4, 15'h7000, 1'b0, 7'sd1, 15'h4800);
    // Exponent gap of 16 shifts the small one out
    run_op("add_far_shift", OP_ADD, 1'b1, 7'sd10, 15'h5a5a, 1'b0, -7'sd6, 15'h7fff);
    check_number("add_far_shift", 1'b1, 7'sd10, 15'h5a5a);
endtask

task automatic test_sub();
    run_op("sub_cancel", OP_SUB, 1'b0, 7'sd0, 15'h4001, 1'b0, 7'sd0, 15'h4000);
    check_number("sub_cancel", 1'b0, -7'sd14, 15'h4000);
    run_op("sub_equal", OP_SUB, 1'b1, -7'sd5, 15'h6abc, 1'b1, -7'sd5, 15'h6abc);
    check_number("sub_equal", 1'b0, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL);
    check_flags("sub_equal", 1'b1, 1'b0, 1'b0);
    // Smaller minus larger at equal exponents
    run_op("sub_negative", OP_SUB, 1'b0, 7'sd0, 15'h4000, 1'b0, 7'sd0, 15'h6000);
    check_number("sub_negative", 1'b1, -7'sd1, 15'h4000);
endtask

task automatic test_mul_random();
    logic [31:0] rnd;
    logic        as;
    logic        bs;
    fpu_exp_t    ae;
    fpu_exp_t    be;
    fpu_mant_t   am;
    fpu_mant_t   bm;

    for (int i = 0; i < NUM_RANDOM_MULS; i++) begin
        rnd = $random(seed);
        as  = rnd[0];
        bs  = rnd[1];
        // Exponents in -30..30 keep the product in range
        ae  = fpu_exp_t'($random(seed) % 31);
        be  = fpu_exp_t'($random(seed) % 31);
        am  = `FPU_MANT_SPECIAL | fpu_mant_t'($random(seed));
        bm  = `FPU_MANT_SPECIAL | fpu_mant_t'($random(seed));
        run_op("mul_random", OP_MUL, as, ae, am, bs, be, bm);
    end
endtask

task automatic test_range();
    run_op("mul_overflow", OP_MUL, 1'b1, 7'sd40, 15'h6000, 1'b0, 7'sd30, 15'h5000);
    check_number("mul_overflow", 1'b1, `FPU_EXP_INF, `FPU_MANT_SPECIAL);
    check_flags("mul_overflow", 1'b0, 1'b1, 1'b0);
    run_op("mul_underflow", OP_MUL, 1'b0, -7'sd40, 15'h4000, 1'b1, -7'sd30, 15'h4000);
    check_number("mul_underflow", 1'b0, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL);
    check_flags("mul_underflow", 1'b1, 1'b0, 1'b1);
endtask

task automatic test_special();
    run_op("add_inf", OP_ADD, 1'b0, `FPU_EXP_INF, `FPU_MANT_SPECIAL, 1'b1, 7'sd3, 15'h5555);
    check_number("add_inf", 1'b0, `FPU_EXP_INF, `FPU_MANT_SPECIAL);
    check_flags("add_inf", 1'b0, 1'b0, 1'b0);
    run_op("mul_inf", OP_MUL, 1'b1, 7'sd2, 15'h7000, 1'b0, `FPU_EXP_INF, `FPU_MANT_SPECIAL);
    check_number("mul_inf", 1'b1, `FPU_EXP_INF, `FPU_MANT_SPECIAL);
    run_op("mul_zero", OP_MUL, 1'b0, 7'sd9, 15'h6000, 1'b1, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL);
    check_number("mul_zero", 1'b0, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL);
    check_flags("mul_zero", 1'b1, 1'b0, 1'b0);
    run_op("add_zero", OP_ADD, 1'b0, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL, 1'b1, -7'sd7, 15'h4321);
    check_number("add_zero", 1'b1, -7'sd7, 15'h4321);
endtask

task automatic test_ignored_start();
    logic      ws;
    fpu_exp_t  we;
    fpu_mant_t wm;
    logic      wz;
    logic      wo;
    logic      wu;

    model_result(OP_MUL, 1'b0, 7'sd1, 15'h4800, 1'b1, 7'sd2, 15'h5000, ws, we, wm, wz, wo, wu);
    @(negedge clk);
    drive_operands(OP_MUL, 1'b0, 7'sd1, 15'h4800, 1'b1, 7'sd2, 15'h5000);
    start = 1'b1;
    @(negedge clk);
    check_status("ignored_start_busy", 1'b0, 1'b0);
    // Start held high with new operands while busy
    drive_operands(OP_ADD, 1'b0, 7'sd20, 15'h7777, 1'b0, 7'sd20, 15'h7777);
    @(negedge clk);
    start = 1'b0;
    while (!done) begin
        @(negedge clk);
    end
    check_status("ignored_start_done", 1'b1, 1'b1);
    check_number("ignored_start_done", ws, we, wm);
    check_flags("ignored_start_done", wz, wo, wu);
    // No second done may follow
    repeat (40) begin
        @(negedge clk);
        check_status("ignored_start_window", 1'b1, 1'b0);
    end
endtask

`endif

// ==== tb/fpu_tb.sv ====
// FPU testbench
// Runs directed and random operations through the FPU and checks
// each result against a reference model of the number format

`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_tb;
    import fpu_format_pkg::*;
    import fpu_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_RANDOM_MULS = 16;
    // Directed operations, plus one for the idle window after the ignored start
    localparam int NUM_OPS         = 15 + NUM_RANDOM_MULS;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 40 * NUM_OPS;

    logic      clk;
    logic      reset;
    logic      start;
    fpu_op_t   op;
    logic      a_sign;
    fpu_exp_t  a_exp;
    fpu_mant_t a_mant;
    logic      b_sign;
    fpu_exp_t  b_exp;
    fpu_mant_t b_mant;
    logic      res_sign;
    fpu_exp_t  res_exp;
    fpu_mant_t res_mant;
    logic      zero_flag;
    logic      overflow_flag;
    logic      underflow_flag;
    logic      idle;
    logic      done;
    integer    seed;

    fpu_top dut (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .op             (op),
        .a_sign         (a_sign),
        .a_exp          (a_exp),
        .a_mant         (a_mant),
        .b_sign         (b_sign),
        .b_exp          (b_exp),
        .b_mant         (b_mant),
        .res_sign       (res_sign),
        .res_exp        (res_exp),
        .res_mant       (res_mant),
        .zero_flag      (zero_flag),
        .overflow_flag  (overflow_flag),
        .underflow_flag (underflow_flag),
        .idle           (idle),
        .done           (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_number(input string name, input logic want_sign,
                                input fpu_exp_t want_exp, input fpu_mant_t want_mant);
        if (res_sign !== want_sign || res_exp !== want_exp || res_mant !== want_mant) begin
            $display("[ERROR] %s: expected sign/exp/mant %0b/%0d/%h, actual %0b/%0d/%h",
                     name, want_sign, want_exp, want_mant, res_sign, res_exp, res_mant);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input logic want_zero,
                               input logic want_ovf, input logic want_unf);
        if (zero_flag !== want_zero || overflow_flag !== want_ovf
                || underflow_flag !== want_unf) begin
            $display("[ERROR] %s: expected zero/ovf/unf %0b/%0b/%0b, actual %0b/%0b/%0b",
                     name, want_zero, want_ovf, want_unf,
                     zero_flag, overflow_flag, underflow_flag);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input logic want_idle, input logic want_done);
        if (idle !== want_idle || done !== want_done) begin
            $display("[ERROR] %s: expected idle/done %0b/%0b, actual %0b/%0b",
                     name, want_idle, want_done, idle, done);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model, truncating throughout
    //////////////////////////////////////////////////

    task automatic model_result(
        input  fpu_op_t   kind,
        input  logic      as,
        input  fpu_exp_t  ae,
        input  fpu_mant_t am,
        input  logic      bs,
        input  fpu_exp_t  be,
        input  fpu_mant_t bm,
        output logic      ws,
        output fpu_exp_t  we,
        output fpu_mant_t wm,
        output logic      wz,
        output logic      wo,
        output logic      wu
    );
        int   ea;
        int   eb;
        int   e;
        int   ma;
        int   mb;
        int   big;
        int   lesser;
        int   mag;
        logic bse;
        logic any_inf;
        logic mul_zero;

        ea       = ae;
        eb       = be;
        any_inf  = (ae == `FPU_EXP_INF) || (be == `FPU_EXP_INF);
        mul_zero = (kind == OP_MUL) && (ae == `FPU_EXP_ZERO || be == `FPU_EXP_ZERO);
        ma       = (ae == `FPU_EXP_ZERO) ? 0 : int'(am);
        mb       = (be == `FPU_EXP_ZERO) ? 0 : int'(bm);

        if (kind == OP_MUL) begin
            ws  = as ^ bs;
            e   = ea + eb;
            mag = (int'(am) * int'(bm)) >> 14;
        end else begin
            bse = (kind == OP_SUB) ? ~bs : bs;
            if (ea >= eb) begin
                e      = ea;
                ws     = as;
                big    = ma;
                lesser = (ea - eb >= 16) ? 0 : mb >> (ea - eb);
            end else begin
                e      = eb;
                ws     = bse;
                big    = mb;
                lesser = (eb - ea >= 16) ? 0 : ma >> (eb - ea);
            end
            if (as == bse) begin
                mag = big + lesser;
            end else begin
                mag = big - lesser;
                if (mag < 0) begin
                    mag = -mag;
                    ws  = ~ws;
                end
            end
        end

        // Leading one back to bit 14
        if (mag != 0) begin
            while (mag >= (1 << 15)) begin
                mag = mag >> 1;
                e++;
            end
            while (mag < (1 << 14)) begin
                mag = mag << 1;
                e--;
            end
        end

        wz = 1'b0;
        wo = 1'b0;
        wu = 1'b0;
        we = fpu_exp_t'(e);
        wm = fpu_mant_t'(mag);
        if (any_inf) begin
            we = `FPU_EXP_INF;
            wm = `FPU_MANT_SPECIAL;
        end else if (mul_zero || mag == 0) begin
            ws = 1'b0;
            we = `FPU_EXP_ZERO;
            wm = `FPU_MANT_SPECIAL;
            wz = 1'b1;
        end else if (e > 62) begin
            we = `FPU_EXP_INF;
            wm = `FPU_MANT_SPECIAL;
            wo = 1'b1;
        end else if (e < -63) begin
            ws = 1'b0;
            we = `FPU_EXP_ZERO;
            wm = `FPU_MANT_SPECIAL;
            wz = 1'b1;
            wu = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic drive_operands(input fpu_op_t kind,
                                  input logic as, input fpu_exp_t ae, input fpu_mant_t am,
                                  input logic bs, input fpu_exp_t be, input fpu_mant_t bm);
        op     = kind;
        a_sign = as;
        a_exp  = ae;
        a_mant = am;
        b_sign = bs;
        b_exp  = be;
        b_mant = bm;
    endtask

    // One operation from start to done, checked against the model
    task automatic run_op(input string name, input fpu_op_t kind,
                          input logic as, input fpu_exp_t ae, input fpu_mant_t am,
                          input logic bs, input fpu_exp_t be, input fpu_mant_t bm);
        logic      ws;
        fpu_exp_t  we;
        fpu_mant_t wm;
        logic      wz;
        logic      wo;
        logic      wu;

        model_result(kind, as, ae, am, bs, be, bm, ws, we, wm, wz, wo, wu);
        @(negedge clk);
        drive_operands(kind, as, ae, am, bs, be, bm);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        check_number(name, ws, we, wm);
        check_flags(name, wz, wo, wu);
    endtask

    `include "fpu_tb_tests.svh"

    initial begin
        seed  = 32'h5b33;
        clk   = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        drive_operands(OP_ADD, 1'b0, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL,
                       1'b0, `FPU_EXP_ZERO, `FPU_MANT_SPECIAL);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_add();
        test_sub();
        test_mul_random();
        test_range();
        test_special();
        test_ignored_start();

        $display("test passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: done never arrived within %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

endmodule

// ==== flist.f ====
+incdir+design
+incdir+tb
design/fpu_format_pkg.sv
design/fpu_ctrl_pkg.sv
design/fpu_decode.sv
design/fpu_execute.sv
design/fpu_result.sv
design/fpu_top.sv
tb/fpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the FPU testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f flist.f --top-module fpu_tb -o fpu_sim

sim_out=$(./obj_dir/fpu_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
else
    echo "Simulation did not report a pass"
    exit 1
fi
